/* Bender.yml */
package:
  name: simple_system

sources:
  - include_dirs:
      - include
    files:
      - verilog/sys_pkg.sv
      - verilog/bus_adapter.sv
      - verilog/data_ram.sv
      - verilog/sim_ctrl.sv
      - verilog/bus_timer.sv
      - verilog/simple_system.sv

  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_simple_system.sv

/* bench/tb_simple_system.sv */
/*
  testbench for the single-host test system
  - clock, reset and watchdog
  - A/D channel request and response tasks
  - directed tests for RAM, unmapped access, back-pressure, simctrl and timer
*/

`include "sys_settings.svh"

module tb_simple_system;

  localparam int clk_half  = 20;
  localparam int drive_dly = 2;
  localparam int hs_limit  = 50;
  // about 100 transfers of a few cycles each plus up to 400 cycles of timer wait
  localparam int timeout_cycles = 4000;

  logic              clk_sys = 1'b0;
  logic              rst_n;
  logic              a_valid;
  sys_pkg::tl_a_op_e a_opcode;
  sys_pkg::addr_t    a_address;
  sys_pkg::be_t      a_mask;
  sys_pkg::data_t    a_data;
  sys_pkg::src_t     a_source;
  logic              a_ready;
  logic              d_valid;
  sys_pkg::tl_d_op_e d_opcode;
  sys_pkg::data_t    d_data;
  logic              d_error;
  sys_pkg::src_t     d_source;
  logic              d_ready;
  logic              char_valid;
  logic [7:0]        char_out;
  logic              halt;
  logic              timer_irq;

  int                errors;
  int                checks;
  sys_pkg::src_t     next_src;
  sys_pkg::src_t     sent_src;
  logic [7:0]        char_log [$];
  sys_pkg::data_t    ram_model [`SYS_RAM_WORDS];

  // last response taken from the D channel
  sys_pkg::tl_d_op_e rsp_opcode;
  sys_pkg::data_t    rsp_data;
  logic              rsp_error;
  sys_pkg::src_t     rsp_source;

  simple_system dut0 (
    .clk_sys_i    (clk_sys),
    .rst_n_i      (rst_n),
    .a_valid_i    (a_valid),
    .a_opcode_i   (a_opcode),
    .a_address_i  (a_address),
    .a_mask_i     (a_mask),
    .a_data_i     (a_data),
    .a_source_i   (a_source),
    .a_ready_o    (a_ready),
    .d_valid_o    (d_valid),
    .d_opcode_o   (d_opcode),
    .d_data_o     (d_data),
    .d_error_o    (d_error),
    .d_source_o   (d_source),
    .d_ready_i    (d_ready),
    .char_valid_o (char_valid),
    .char_o       (char_out),
    .halt_o       (halt),
    .timer_irq_o  (timer_irq)
  );

  always #clk_half clk_sys = ~clk_sys;

  // characters seen on the output strobe at mid-cycle
  always @(negedge clk_sys) begin
    if (char_valid === 1'b1) begin
      char_log.push_back(char_out);
    end
  end

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", test, what, exp, act);
    end
  endtask

  task automatic check_true(input string test, input logic cond, input string msg);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("ERROR %s: %s", test, msg);
    end
  endtask

  function automatic sys_pkg::data_t merge_lanes(input sys_pkg::data_t old_w,
                                                 input sys_pkg::data_t new_w,
                                                 input sys_pkg::be_t mask);
    sys_pkg::data_t res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic set_d_ready(input logic value);
    d_ready = value;
  endtask

  // one A beat held until the edge where a_ready_o is seen
  task automatic send_beat(input string test, input sys_pkg::tl_a_op_e op,
                           input sys_pkg::addr_t addr, input sys_pkg::be_t mask,
                           input sys_pkg::data_t data);
    logic accepted;
    int   waited;
    accepted  = 1'b0;
    waited    = 0;
    sent_src  = next_src;
    next_src  = next_src + 8'd1;
    a_valid   = 1'b1;
    a_opcode  = op;
    a_address = addr;
    a_mask    = mask;
    a_data    = data;
    a_source  = sent_src;
    while (!accepted && waited < hs_limit) begin
      accepted = (a_ready === 1'b1);
      @(posedge clk_sys);
      #drive_dly;
      waited++;
    end
    a_valid = 1'b0;
    check_true(test, accepted, "request not accepted, a_ready_o stayed low");
  endtask

  task automatic take_response(input string test);
    logic taken;
    int   waited;
    taken  = 1'b0;
    waited = 0;
    while (!taken && waited < hs_limit) begin
      if (d_valid === 1'b1 && d_ready === 1'b1) begin
        taken      = 1'b1;
        rsp_opcode = d_opcode;
        rsp_data   = d_data;
        rsp_error  = d_error;
        rsp_source = d_source;
      end
      @(posedge clk_sys);
      #drive_dly;
      waited++;
    end
    check_true(test, taken, "no response arrived on the D channel");
  endtask

  task automatic put_word(input string test, input sys_pkg::addr_t addr,
                          input sys_pkg::be_t mask, input sys_pkg::data_t data);
    if (mask == 4'hF) begin
      send_beat(test, sys_pkg::PutFullData, addr, mask, data);
    end else begin
      send_beat(test, sys_pkg::PutPartialData, addr, mask, data);
    end
    take_response(test);
    check_value(test, "put opcode", sys_pkg::AccessAck, rsp_opcode);
    check_value(test, "put error", 1'b0, rsp_error);
    check_value(test, "put source", sent_src, rsp_source);
  endtask

  task automatic read_word(input string test, input sys_pkg::addr_t addr,
                           output sys_pkg::data_t data);
    send_beat(test, sys_pkg::Get, addr, 4'hF, '0);
    take_response(test);
    check_value(test, "get opcode", sys_pkg::AccessAckData, rsp_opcode);
    check_value(test, "get error", 1'b0, rsp_error);
    check_value(test, "get source", sent_src, rsp_source);
    data = rsp_data;
  endtask

  task automatic get_word(input string test, input sys_pkg::addr_t addr,
                          input sys_pkg::data_t exp);
    sys_pkg::data_t act;
    read_word(test, addr, act);
    check_value(test, "read data", exp, act);
  endtask

  task automatic ram_rw();
    int unsigned    idx [$];
    int unsigned    w;
    sys_pkg::data_t value;
    for (int i = 0; i < 32; i++) begin
      w     = $urandom % `SYS_RAM_WORDS;
      value = $urandom;
      put_word("ram_rw", `SYS_RAM_BASE + (w << 2), 4'hF, value);
      ram_model[w] = value;
      idx.push_back(w);
    end
    // repeated offsets expect the last value written
    foreach (idx[i]) begin
      get_word("ram_rw", `SYS_RAM_BASE + (idx[i] << 2), ram_model[idx[i]]);
    end
  endtask

  task automatic ram_mask();
    sys_pkg::be_t   masks [4] = '{4'b0001, 4'b0110, 4'b1000, 4'b1011};
    sys_pkg::data_t expected;
    sys_pkg::data_t value;
    expected = 32'h1122_3344;
    put_word("ram_mask", `SYS_RAM_BASE + 32'h40, 4'hF, expected);
    get_word("ram_mask", `SYS_RAM_BASE + 32'h40, expected);
    foreach (masks[i]) begin
      value    = $urandom;
      put_word("ram_mask", `SYS_RAM_BASE + 32'h40, masks[i], value);
      expected = merge_lanes(expected, value, masks[i]);
      get_word("ram_mask", `SYS_RAM_BASE + 32'h40, expected);
    end
    ram_model[16] = expected;
  endtask

  task automatic unmapped_addr();
    send_beat("unmapped", sys_pkg::Get, 32'h0050_0000, 4'hF, '0);
    take_response("unmapped");
    check_value("unmapped", "error", 1'b1, rsp_error);
    check_value("unmapped", "data", 32'h0, rsp_data);
    check_value("unmapped", "source", sent_src, rsp_source);
    check_value("unmapped", "opcode", sys_pkg::AccessAckData, rsp_opcode);
    get_word("unmapped", `SYS_RAM_BASE + 32'h40, ram_model[16]);
  endtask

  task automatic backpressure();
    int                hold;
    int                waited;
    sys_pkg::tl_d_op_e held_op;
    sys_pkg::data_t    held_data;
    logic              held_err;
    sys_pkg::src_t     held_src;
    hold   = 1 + ($urandom % 10);
    waited = 0;
    set_d_ready(1'b0);
    send_beat("backpressure", sys_pkg::Get, `SYS_RAM_BASE + 32'h40, 4'hF, '0);
    while (d_valid !== 1'b1 && waited < hs_limit) begin
      @(posedge clk_sys);
      #drive_dly;
      waited++;
    end
    check_true("backpressure", d_valid, "no response while d_ready_i was low");
    held_op   = d_opcode;
    held_data = d_data;
    held_err  = d_error;
    held_src  = d_source;
    repeat (hold) begin
      check_true("backpressure", a_ready === 1'b0, "a_ready_o high while response is held");
      @(posedge clk_sys);
      #drive_dly;
      check_value("backpressure", "held valid", 1'b1, d_valid);
      check_value("backpressure", "held opcode", held_op, d_opcode);
      check_value("backpressure", "held data", held_data, d_data);
      check_value("backpressure", "held error", held_err, d_error);
      check_value("backpressure", "held source", held_src, d_source);
    end
    set_d_ready(1'b1);
    take_response("backpressure");
    check_value("backpressure", "read data", ram_model[16], rsp_data);
    check_value("backpressure", "opcode", sys_pkg::AccessAckData, rsp_opcode);
    check_value("backpressure", "source", sent_src, rsp_source);
    check_value("backpressure", "error", 1'b0, rsp_error);
  endtask

  task automatic simctrl_chars();
    logic [7:0]     text [3] = '{8'h4f, 8'h4b, 8'h0a};
    sys_pkg::data_t value;
    char_log.delete();
    check_value("sim_ctrl", "halt before write", 1'b0, halt);
    foreach (text[i]) begin
      // random upper bytes that the device ignores
      value      = $urandom;
      value[7:0] = text[i];
      put_word("sim_ctrl", `SYS_SIMCTRL_BASE + `SYS_SIMCTRL_CHAR, 4'hF, value);
    end
    check_value("sim_ctrl", "char count", 3, char_log.size());
    foreach (text[i]) begin
      if (i < char_log.size()) begin
        check_value("sim_ctrl", "char", text[i], char_log[i]);
      end
    end
    put_word("sim_ctrl", `SYS_SIMCTRL_BASE + `SYS_SIMCTRL_HALT, 4'hF, 32'h1);
    check_value("sim_ctrl", "halt", 1'b1, halt);
    get_word("sim_ctrl", `SYS_SIMCTRL_BASE + `SYS_SIMCTRL_HALT, 32'h1);
    repeat (5) @(posedge clk_sys);
    #drive_dly;
    check_value("sim_ctrl", "halt sticky", 1'b1, halt);
    check_value("sim_ctrl", "char count after halt", 3, char_log.size());
  endtask

  task automatic timer_compare();
    sys_pkg::data_t first;
    sys_pkg::data_t second;
    logic           seen;
    int             waited;
    put_word("timer", `SYS_TIMER_BASE + `SYS_TIMER_MTIME_LO, 4'hF, 32'h0);
    put_word("timer", `SYS_TIMER_BASE + `SYS_TIMER_MTIME_HI, 4'hF, 32'h0);
    put_word("timer", `SYS_TIMER_BASE + `SYS_TIMER_CMP_HI, 4'hF, 32'h0);
    put_word("timer", `SYS_TIMER_BASE + `SYS_TIMER_CMP_LO, 4'hF, 32'd200);
    repeat (2) @(posedge clk_sys);
    #drive_dly;
    check_value("timer", "irq after setup", 1'b0, timer_irq);
    read_word("timer", `SYS_TIMER_BASE + `SYS_TIMER_MTIME_LO, first);
    read_word("timer", `SYS_TIMER_BASE + `SYS_TIMER_MTIME_LO, second);
    check_true("timer", second > first, "mtime did not increase between reads");
    seen   = 1'b0;
    waited = 0;
    while (!seen && waited < 400) begin
      seen = (timer_irq === 1'b1);
      if (!seen) begin
        @(posedge clk_sys);
        #drive_dly;
        waited++;
      end
    end
    check_true("timer", seen, "timer_irq_o did not rise within 400 cycles");
  endtask

  initial begin
    void'($urandom(32'h722b_19c1));
    errors    = 0;
    checks    = 0;
    next_src  = 8'h10;
    sent_src  = 8'h00;
    rst_n     = 1'b0;
    a_valid   = 1'b0;
    a_opcode  = sys_pkg::Get;
    a_address = '0;
    a_mask    = '0;
    a_data    = '0;
    a_source  = '0;
    d_ready   = 1'b1;
    repeat (10) @(posedge clk_sys);
    #drive_dly;
    check_value("reset", "a_ready_o", 1'b0, a_ready);
    check_value("reset", "d_valid_o", 1'b0, d_valid);
    check_value("reset", "char_valid_o", 1'b0, char_valid);
    check_value("reset", "halt_o", 1'b0, halt);
    check_value("reset", "timer_irq_o", 1'b0, timer_irq);
    rst_n = 1'b1;
    @(posedge clk_sys);
    #drive_dly;

    ram_rw();
    ram_mask();
    unmapped_addr();
    backpressure();
    simctrl_chars();
    timer_compare();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk_sys);
    $display("watchdog: run did not finish within %0d cycles", timeout_cycles);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
verilog/sys_pkg.sv
verilog/bus_adapter.sv
verilog/data_ram.sv
verilog/sim_ctrl.sv
verilog/bus_timer.sv
verilog/simple_system.sv
bench/tb_simple_system.sv

/* include/sys_settings.svh */
/*
  bus fabric settings
  - data path widths and source tag width
  - device memory map with a 64 KiB window per device
  - register offsets inside the simctrl and timer windows
  - data RAM depth in words
*/

`ifndef SYS_SETTINGS_SVH
`define SYS_SETTINGS_SVH

// data path
`define SYS_ADDR_W 32
`define SYS_DATA_W 32
`define SYS_SRC_W 8

// data RAM, 64 KiB
`define SYS_RAM_WORDS 16384

// memory map
`define SYS_RAM_BASE 32'h0010_0000
`define SYS_SIMCTRL_BASE 32'h0002_0000
`define SYS_TIMER_BASE 32'h0003_0000
`define SYS_DEV_MASK 32'hFFFF_0000

// simctrl registers
`define SYS_SIMCTRL_CHAR 32'h0000_0000
`define SYS_SIMCTRL_HALT 32'h0000_0008

// timer registers
`define SYS_TIMER_MTIME_LO 32'h0000_0000
`define SYS_TIMER_MTIME_HI 32'h0000_0004
`define SYS_TIMER_CMP_LO 32'h0000_0008
`define SYS_TIMER_CMP_HI 32'h0000_000C

`endif

/* verilog/bus_adapter.sv */
/*
  A/D channel to strobe bus adapter
  - accepts one A beat at a time and latches it
  - decodes the target device from the memory map
  - strobes the device for one cycle
  - holds the D response until it is taken, error for unmapped addresses
*/

`include "sys_settings.svh"

module bus_adapter (
  input  logic                     clk_sys_i,
  input  logic                     rst_n_i,
  input  logic                     a_valid_i,
  input  sys_pkg::tl_a_op_e        a_opcode_i,
  input  sys_pkg::addr_t           a_address_i,
  input  sys_pkg::be_t             a_mask_i,
  input  sys_pkg::data_t           a_data_i,
  input  sys_pkg::src_t            a_source_i,
  output logic                     a_ready_o,
  output logic                     d_valid_o,
  output sys_pkg::tl_d_op_e        d_opcode_o,
  output sys_pkg::data_t           d_data_o,
  output logic                     d_error_o,
  output sys_pkg::src_t            d_source_o,
  input  logic                     d_ready_i,
  output sys_pkg::addr_t           dev_addr_o,
  output logic                     dev_we_o,
  output sys_pkg::be_t             dev_be_o,
  output sys_pkg::data_t           dev_wdata_o,
  output logic                     ram_req_o,
  output logic                     simctrl_req_o,
  output logic                     timer_req_o,
  input  logic                     ram_rvalid_i,
  input  sys_pkg::data_t           ram_rdata_i,
  input  logic                     simctrl_rvalid_i,
  input  sys_pkg::data_t           simctrl_rdata_i,
  input  logic                     timer_rvalid_i,
  input  sys_pkg::data_t           timer_rdata_i
);

  sys_pkg::adapter_state_e state_q;
  sys_pkg::adapter_state_e state_d;
  sys_pkg::bus_device_e    a_dev;
  sys_pkg::bus_device_e    dev_q;
  logic                    a_ready_q;
  logic                    d_valid_q;
  logic                    a_fire;
  logic                    d_fire;
  logic                    rsp_valid;
  sys_pkg::data_t          rsp_rdata;
  sys_pkg::addr_t          addr_q;
  sys_pkg::be_t            be_q;
  sys_pkg::data_t          wdata_q;
  logic                    we_q;
  sys_pkg::src_t           src_q;
  sys_pkg::tl_d_op_e       d_opcode_q;
  sys_pkg::data_t          d_data_q;
  logic                    d_error_q;

  assign a_fire = a_valid_i & a_ready_q;
  assign d_fire = d_valid_q & d_ready_i;

  // address decode on the incoming beat
  always_comb begin
    if ((a_address_i & `SYS_DEV_MASK) == `SYS_RAM_BASE) begin
      a_dev = sys_pkg::Ram;
    end else if ((a_address_i & `SYS_DEV_MASK) == `SYS_SIMCTRL_BASE) begin
      a_dev = sys_pkg::SimCtrl;
    end else if ((a_address_i & `SYS_DEV_MASK) == `SYS_TIMER_BASE) begin
      a_dev = sys_pkg::Timer;
    end else begin
      a_dev = sys_pkg::NoDevice;
    end
  end

  // response from the device addressed by the latched beat
  always_comb begin
    case (dev_q)
      sys_pkg::Ram: begin
        rsp_valid = ram_rvalid_i;
        rsp_rdata = ram_rdata_i;
      end
      sys_pkg::SimCtrl: begin
        rsp_valid = simctrl_rvalid_i;
        rsp_rdata = simctrl_rdata_i;
      end
      sys_pkg::Timer: begin
        rsp_valid = timer_rvalid_i;
        rsp_rdata = timer_rdata_i;
      end
      default: begin
        rsp_valid = 1'b0;
        rsp_rdata = '0;
      end
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      sys_pkg::Idle: begin
        if (a_fire) begin
          state_d = sys_pkg::Access;
        end
      end
      sys_pkg::Access: state_d = sys_pkg::Respond;
      sys_pkg::Respond: begin
        if (d_fire) begin
          state_d = sys_pkg::Idle;
        end
      end
      default: state_d = sys_pkg::Idle;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= sys_pkg::Idle;
      a_ready_q <= 1'b0;
      d_valid_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      // ready follows the state one edge ahead, low straight out of reset
      a_ready_q <= (state_d == sys_pkg::Idle);
      if (state_q == sys_pkg::Access && dev_q == sys_pkg::NoDevice) begin
        d_valid_q <= 1'b1;
      end else if (state_q == sys_pkg::Respond && !d_valid_q && rsp_valid) begin
        d_valid_q <= 1'b1;
      end else if (d_fire) begin
        d_valid_q <= 1'b0;
      end
    end
  end

  // latched beat and held response
  always_ff @(posedge clk_sys_i) begin
    if (a_fire) begin
      addr_q     <= a_address_i;
      be_q       <= a_mask_i;
      wdata_q    <= a_data_i;
      we_q       <= ~a_opcode_i[2];
      src_q      <= a_source_i;
      dev_q      <= a_dev;
      d_opcode_q <= a_opcode_i[2] ? sys_pkg::AccessAckData : sys_pkg::AccessAck;
    end
    if (state_q == sys_pkg::Access && dev_q == sys_pkg::NoDevice) begin
      d_data_q  <= '0;
      d_error_q <= 1'b1;
    end else if (state_q == sys_pkg::Respond && !d_valid_q && rsp_valid) begin
      d_data_q  <= we_q ? '0 : rsp_rdata;
      d_error_q <= 1'b0;
    end
  end

  assign a_ready_o     = a_ready_q;
  assign d_valid_o     = d_valid_q;
  assign d_opcode_o    = d_opcode_q;
  assign d_data_o      = d_data_q;
  assign d_error_o     = d_error_q;
  assign d_source_o    = src_q;

  assign dev_addr_o    = addr_q;
  assign dev_we_o      = we_q;
  assign dev_be_o      = be_q;
  assign dev_wdata_o   = wdata_q;
  assign ram_req_o     = (state_q == sys_pkg::Access) && (dev_q == sys_pkg::Ram);
  assign simctrl_req_o = (state_q == sys_pkg::Access) && (dev_q == sys_pkg::SimCtrl);
  assign timer_req_o   = (state_q == sys_pkg::Access) && (dev_q == sys_pkg::Timer);

endmodule

/* verilog/bus_timer.sv */
/*
  machine timer
  - free-running 64-bit mtime, reset to zero
  - 64-bit mtimecmp, reset to all ones
  - both readable and byte-writable as two words
  - registered interrupt level while mtime >= mtimecmp
*/

`include "sys_settings.svh"

module bus_timer (
  input  logic           clk_sys_i,
  input  logic           rst_n_i,
  input  logic           req_i,
  input  logic           we_i,
  input  sys_pkg::be_t   be_i,
  input  sys_pkg::addr_t addr_i,
  input  sys_pkg::data_t wdata_i,
  output logic           rvalid_o,
  output sys_pkg::data_t rdata_o,
  output logic           irq_o
);

  logic [63:0]    mtime_q;
  logic [63:0]    mtimecmp_q;
  logic           irq_q;
  logic           wr_en;
  sys_pkg::addr_t offset;

  // byte lanes of new_w under the mask, rest from old_w
  function automatic sys_pkg::data_t merge_bytes(sys_pkg::data_t old_w,
                                                 sys_pkg::data_t new_w,
                                                 sys_pkg::be_t   be);
    sys_pkg::data_t res;
    res = old_w;
    for (int i = 0; i < `SYS_DATA_W / 8; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign offset = addr_i & ~(`SYS_DEV_MASK);
  assign wr_en  = req_i & we_i;

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_q      <= 1'b0;
      rvalid_o   <= 1'b0;
    end else begin
      rvalid_o <= req_i;
      irq_q    <= (mtime_q >= mtimecmp_q);
      // a write to mtime takes the place of the increment
      if (wr_en && offset == `SYS_TIMER_MTIME_LO) begin
        mtime_q <= {mtime_q[63:32], merge_bytes(mtime_q[31:0], wdata_i, be_i)};
      end else if (wr_en && offset == `SYS_TIMER_MTIME_HI) begin
        mtime_q <= {merge_bytes(mtime_q[63:32], wdata_i, be_i), mtime_q[31:0]};
      end else begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr_en && offset == `SYS_TIMER_CMP_LO) begin
        mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0], wdata_i, be_i);
      end
      if (wr_en && offset == `SYS_TIMER_CMP_HI) begin
        mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], wdata_i, be_i);
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      case (offset)
        `SYS_TIMER_MTIME_LO: rdata_o <= mtime_q[31:0];
        `SYS_TIMER_MTIME_HI: rdata_o <= mtime_q[63:32];
        `SYS_TIMER_CMP_LO:   rdata_o <= mtimecmp_q[31:0];
        `SYS_TIMER_CMP_HI:   rdata_o <= mtimecmp_q[63:32];
        default:             rdata_o <= '0;
      endcase
    end
  end

  assign irq_o = irq_q;

endmodule

/* verilog/data_ram.sv */
/*
  single-port data RAM
  - word array indexed inside the device window
  - byte-masked writes
  - registered read data and rvalid one cycle after req
*/

`include "sys_settings.svh"

module data_ram (
  input  logic           clk_sys_i,
  input  logic           rst_n_i,
  input  logic           req_i,
  input  logic           we_i,
  input  sys_pkg::be_t   be_i,
  input  sys_pkg::addr_t addr_i,
  input  sys_pkg::data_t wdata_i,
  output logic           rvalid_o,
  output sys_pkg::data_t rdata_o
);

  localparam int unsigned idx_w     = $clog2(`SYS_RAM_WORDS);
  localparam int unsigned num_bytes = `SYS_DATA_W / 8;

  sys_pkg::data_t   mem [`SYS_RAM_WORDS];
  logic [idx_w-1:0] word_idx;

  // word address, byte offset bits dropped
  assign word_idx = addr_i[idx_w+1:2];

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int i = 0; i < num_bytes; i++) begin
          if (be_i[i]) begin
            mem[word_idx][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end
      // old word, also on writes
      rdata_o <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

/* verilog/sim_ctrl.sv */
/*
  simulation control device
  - character output strobe on writes to CHAR
  - sticky halt level set through HALT
  - HALT readable, all other offsets read zero
*/

`include "sys_settings.svh"

module sim_ctrl (
  input  logic           clk_sys_i,
  input  logic           rst_n_i,
  input  logic           req_i,
  input  logic           we_i,
  input  sys_pkg::be_t   be_i,
  input  sys_pkg::addr_t addr_i,
  input  sys_pkg::data_t wdata_i,
  output logic           rvalid_o,
  output sys_pkg::data_t rdata_o,
  output logic           char_valid_o,
  output logic [7:0]     char_o,
  output logic           halt_o
);

  sys_pkg::addr_t offset;
  logic           halt_q;
  logic           halt_set;

  assign offset = addr_i & ~(`SYS_DEV_MASK);

  // character goes out in the strobe cycle
  assign char_valid_o = req_i & we_i & be_i[0] & (offset == `SYS_SIMCTRL_CHAR);
  assign char_o       = wdata_i[7:0];

  assign halt_set = req_i & we_i & be_i[0] & wdata_i[0] & (offset == `SYS_SIMCTRL_HALT);

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      halt_q   <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
      if (halt_set) begin
        halt_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      rdata_o <= (offset == `SYS_SIMCTRL_HALT) ? {{(`SYS_DATA_W-1){1'b0}}, halt_q} : '0;
    end
  end

  assign halt_o = halt_q;

endmodule

/* verilog/simple_system.sv */
/*
  single-host test system
  - A/D channel adapter
  - data RAM, simulation control and machine timer behind it
*/

module simple_system (
  input  logic              clk_sys_i,
  input  logic              rst_n_i,
  input  logic              a_valid_i,
  input  sys_pkg::tl_a_op_e a_opcode_i,
  input  sys_pkg::addr_t    a_address_i,
  input  sys_pkg::be_t      a_mask_i,
  input  sys_pkg::data_t    a_data_i,
  input  sys_pkg::src_t     a_source_i,
  output logic              a_ready_o,
  output logic              d_valid_o,
  output sys_pkg::tl_d_op_e d_opcode_o,
  output sys_pkg::data_t    d_data_o,
  output logic              d_error_o,
  output sys_pkg::src_t     d_source_o,
  input  logic              d_ready_i,
  output logic              char_valid_o,
  output logic [7:0]        char_o,
  output logic              halt_o,
  output logic              timer_irq_o
);

  // shared strobe bus
  sys_pkg::addr_t dev_addr;
  logic           dev_we;
  sys_pkg::be_t   dev_be;
  sys_pkg::data_t dev_wdata;

  // per device request and response
  logic           ram_req;
  logic           ram_rvalid;
  sys_pkg::data_t ram_rdata;
  logic           simctrl_req;
  logic           simctrl_rvalid;
  sys_pkg::data_t simctrl_rdata;
  logic           timer_req;
  logic           timer_rvalid;
  sys_pkg::data_t timer_rdata;

  bus_adapter u_bus_adapter (
    .clk_sys_i        (clk_sys_i),
    .rst_n_i          (rst_n_i),
    .a_valid_i        (a_valid_i),
    .a_opcode_i       (a_opcode_i),
    .a_address_i      (a_address_i),
    .a_mask_i         (a_mask_i),
    .a_data_i         (a_data_i),
    .a_source_i       (a_source_i),
    .a_ready_o        (a_ready_o),
    .d_valid_o        (d_valid_o),
    .d_opcode_o       (d_opcode_o),
    .d_data_o         (d_data_o),
    .d_error_o        (d_error_o),
    .d_source_o       (d_source_o),
    .d_ready_i        (d_ready_i),
    .dev_addr_o       (dev_addr),
    .dev_we_o         (dev_we),
    .dev_be_o         (dev_be),
    .dev_wdata_o      (dev_wdata),
    .ram_req_o        (ram_req),
    .simctrl_req_o    (simctrl_req),
    .timer_req_o      (timer_req),
    .ram_rvalid_i     (ram_rvalid),
    .ram_rdata_i      (ram_rdata),
    .simctrl_rvalid_i (simctrl_rvalid),
    .simctrl_rdata_i  (simctrl_rdata),
    .timer_rvalid_i   (timer_rvalid),
    .timer_rdata_i    (timer_rdata)
  );

  data_ram u_data_ram (
    .clk_sys_i (clk_sys_i),
    .rst_n_i   (rst_n_i),
    .req_i     (ram_req),
    .we_i      (dev_we),
    .be_i      (dev_be),
    .addr_i    (dev_addr),
    .wdata_i   (dev_wdata),
    .rvalid_o  (ram_rvalid),
    .rdata_o   (ram_rdata)
  );

  sim_ctrl u_sim_ctrl (
    .clk_sys_i    (clk_sys_i),
    .rst_n_i      (rst_n_i),
    .req_i        (simctrl_req),
    .we_i         (dev_we),
    .be_i         (dev_be),
    .addr_i       (dev_addr),
    .wdata_i      (dev_wdata),
    .rvalid_o     (simctrl_rvalid),
    .rdata_o      (simctrl_rdata),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

  bus_timer u_bus_timer (
    .clk_sys_i (clk_sys_i),
    .rst_n_i   (rst_n_i),
    .req_i     (timer_req),
    .we_i      (dev_we),
    .be_i      (dev_be),
    .addr_i    (dev_addr),
    .wdata_i   (dev_wdata),
    .rvalid_o  (timer_rvalid),
    .rdata_o   (timer_rdata),
    .irq_o     (timer_irq_o)
  );

endmodule

/* verilog/sys_pkg.sv */
/*
  shared bus types
  - address, data, byte mask and source tag vectors
  - A and D channel opcodes
  - decoded device and adapter state enums
*/

`include "sys_settings.svh"

package sys_pkg;

  typedef logic [`SYS_ADDR_W-1:0] addr_t;
  typedef logic [`SYS_DATA_W-1:0] data_t;
  typedef logic [`SYS_DATA_W/8-1:0] be_t;
  typedef logic [`SYS_SRC_W-1:0] src_t;

  // A channel opcodes, only the UL subset
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  typedef enum logic [1:0] {
    Ram,
    SimCtrl,
    Timer,
    NoDevice
  } bus_device_e;

  typedef enum logic [1:0] {
    Idle,
    Access,
    Respond
  } adapter_state_e;

endpackage
